// File: rtl/alu_pkg.sv
package alu_pkg;

    localparam int opcode_width = 6;  // alucode field width
    localparam int xlen_default = 32; // operand width unless overridden at the top
    localparam int mul_lanes    = 8;  // partial-product accumulators
    localparam int mul_steps    = xlen_default / mul_lanes; // accumulate cycles

    // alucode, same ordering as the core decoder
    typedef enum logic [opcode_width-1:0] {
        alu_add    = 6'd0,
        alu_sub    = 6'd1,
        alu_slt    = 6'd2,
        alu_sltu   = 6'd3,
        alu_xor    = 6'd4,
        alu_or     = 6'd5,
        alu_and    = 6'd6,
        alu_sll    = 6'd7,
        alu_srl    = 6'd8,
        alu_sra    = 6'd9,
        alu_mul    = 6'd10,
        alu_mulh   = 6'd11,
        alu_mulhsu = 6'd12,
        alu_mulhu  = 6'd13,
        alu_div    = 6'd14,
        alu_divu   = 6'd15,
        alu_rem    = 6'd16,
        alu_remu   = 6'd17,
        alu_lui    = 6'd18
    } alu_op_e;

    // multiplier sequence
    typedef enum logic [1:0] {
        mul_idle,       // load operands, clear lanes
        mul_accumulate, // add one partial product per lane
        mul_reduce,     // pairwise lane fold
        mul_done        // product in lane 0, busy low
    } mul_phase_e;

    // divider sequence
    typedef enum logic [1:0] {
        div_idle,
        div_iterate, // one quotient bit per cycle, msb first
        div_done
    } div_phase_e;

    function automatic logic is_mul_op(alu_op_e op);
        return op inside {alu_mul, alu_mulh, alu_mulhsu, alu_mulhu};
    endfunction

    function automatic logic is_div_op(alu_op_e op);
        return op inside {alu_div, alu_divu, alu_rem, alu_remu};
    endfunction

endpackage

// File: rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu #(
    parameter int xlen = alu_pkg::xlen_default
) (
    input  alu_pkg::alu_op_e  alucode,
    input  logic [xlen-1:0]   a,
    input  logic [xlen-1:0]   b,
    output logic [xlen-1:0]   result
);

    localparam int shamt_w = $clog2(xlen); // 5 for rv32

    logic [shamt_w-1:0] shamt;
    logic [xlen-1:0]    sum;
    logic [xlen-1:0]    addend;

    assign shamt = b[shamt_w-1:0]; // upper bits of b ignored

    // sub shares the adder, two's complement of b
    assign addend = (alucode == alu_pkg::alu_sub) ? (~b + 1'b1) : b;
    assign sum    = a + addend;

    always_comb begin
        case (alucode)
            alu_pkg::alu_add,
            alu_pkg::alu_sub:  result = sum;
            alu_pkg::alu_slt: begin
                // signed compare
                result = ($signed(a) < $signed(b)) ? xlen'(1) : '0;
            end
            alu_pkg::alu_sltu: begin
                result = (a < b) ? xlen'(1) : '0;
            end
            alu_pkg::alu_xor:  result = a ^ b;
            alu_pkg::alu_or:   result = a | b;
            alu_pkg::alu_and:  result = a & b;
            alu_pkg::alu_sll:  result = a << shamt;
            alu_pkg::alu_srl:  result = a >> shamt;
            alu_pkg::alu_sra:  result = $signed(a) >>> shamt; // sign fill
            alu_pkg::alu_lui:  result = b; // immediate already shifted by decode
            default:           result = '0; // mul/div handled elsewhere
        endcase
    end

endmodule

// File: rtl/multiplier.sv
`timescale 1ns/1ps

module multiplier #(
    parameter int xlen = alu_pkg::xlen_default
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid,
    input  alu_pkg::alu_op_e  alucode,
    input  logic [xlen-1:0]   a,
    input  logic [xlen-1:0]   b,
    output logic [xlen-1:0]   result,
    output logic              busy
);

    localparam int step_w        = $clog2(alu_pkg::mul_steps);
    localparam int reduce_rounds = $clog2(alu_pkg::mul_lanes); // 8 -> 4 -> 2 -> 1
    localparam int busy_len      = 1 + alu_pkg::mul_steps + reduce_rounds; // load, acc, reduce

    alu_pkg::mul_phase_e phase;
    logic [step_w-1:0]   step; // accumulate or reduce round

    logic [xlen-1:0]     op_a;   // magnitude of a where signed
    logic [xlen-1:0]     op_b;
    logic                negate; // product sign
    logic [2*xlen-1:0]   lane [alu_pkg::mul_lanes];
    logic [2*xlen-1:0]   pp   [alu_pkg::mul_lanes];
    logic [2*xlen-1:0]   product;
    logic                req;

    assign req  = valid & alu_pkg::is_mul_op(alucode);
    assign busy = req & (phase != alu_pkg::mul_done);

    // lane k takes bit step*lanes + k of op_b this cycle
    for (genvar k = 0; k < alu_pkg::mul_lanes; k++) begin : g_pp
        assign pp[k] = op_b[step * alu_pkg::mul_lanes + k]
                     ? ({{xlen{1'b0}}, op_a} << (step * alu_pkg::mul_lanes + k))
                     : '0;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase <= alu_pkg::mul_idle;
            step  <= '0;
        end else if (req) begin // frozen while valid drops
            case (phase)
                alu_pkg::mul_idle: begin
                    phase <= alu_pkg::mul_accumulate;
                    step  <= '0;
                end
                alu_pkg::mul_accumulate: begin
                    if (step == step_w'(alu_pkg::mul_steps - 1)) begin
                        phase <= alu_pkg::mul_reduce;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                alu_pkg::mul_reduce: begin
                    if (step == step_w'(reduce_rounds - 1))
                        phase <= alu_pkg::mul_done;
                    else
                        step <= step + 1'b1;
                end
                default: phase <= alu_pkg::mul_idle; // retire edge
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (req) begin
            case (phase)
                alu_pkg::mul_idle: begin
                    for (int i = 0; i < alu_pkg::mul_lanes; i++)
                        lane[i] <= '0;
                    case (alucode)
                        alu_pkg::alu_mulh: begin
                            op_a   <= a[xlen-1] ? -a : a;
                            op_b   <= b[xlen-1] ? -b : b;
                            negate <= a[xlen-1] ^ b[xlen-1];
                        end
                        alu_pkg::alu_mulhsu: begin // only a is signed
                            op_a   <= a[xlen-1] ? -a : a;
                            op_b   <= b;
                            negate <= a[xlen-1];
                        end
                        default: begin // mul low half is sign agnostic
                            op_a   <= a;
                            op_b   <= b;
                            negate <= 1'b0;
                        end
                    endcase
                end
                alu_pkg::mul_accumulate: begin
                    for (int i = 0; i < alu_pkg::mul_lanes; i++)
                        lane[i] <= lane[i] + pp[i];
                end
                alu_pkg::mul_reduce: begin
                    // upper lanes go stale, lane 0 is exact after the last round
                    for (int i = 0; i < alu_pkg::mul_lanes / 2; i++)
                        lane[i] <= lane[2*i] + lane[2*i+1];
                end
                default: ;
            endcase
        end
    end

    assign product = negate ? -lane[0] : lane[0];
    assign result  = (alucode == alu_pkg::alu_mul) ? product[xlen-1:0]
                                                   : product[2*xlen-1:xlen];

    // step stays below the round count while reducing
    a_reduce_step_legal: assert property (@(posedge clk) disable iff (!reset)
        (phase == alu_pkg::mul_reduce) |-> (step < step_w'(reduce_rounds)));

    // request held from idle, busy drops once the full sequence has run
    a_busy_length: assert property (@(posedge clk) disable iff (!reset)
        (req && phase == alu_pkg::mul_idle) ##1 req [*(busy_len-1)] |=> !busy);

endmodule

// File: rtl/divider.sv
`timescale 1ns/1ps

module divider #(
    parameter int xlen = alu_pkg::xlen_default
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid,
    input  alu_pkg::alu_op_e  alucode,
    input  logic [xlen-1:0]   a,
    input  logic [xlen-1:0]   b,
    output logic [xlen-1:0]   result,
    output logic              busy
);

    localparam int cnt_w = $clog2(xlen);

    alu_pkg::div_phase_e phase;
    logic [cnt_w-1:0]    count; // current quotient bit

    logic [xlen-1:0]     rem;  // partial remainder, ends as |remainder|
    logic [xlen-1:0]     dvsr; // divisor magnitude
    logic [xlen-1:0]     quo;
    logic                neg_q;
    logic                neg_r; // remainder follows dividend sign
    logic [2*xlen-1:0]   diff;
    logic                q_bit;

    logic                req;
    logic                signed_op;
    logic                is_quot; // div/divu vs rem/remu
    logic                div_zero;
    logic                overflow;
    logic                exc;

    assign req       = valid & alu_pkg::is_div_op(alucode);
    assign signed_op = alucode inside {alu_pkg::alu_div, alu_pkg::alu_rem};
    assign is_quot   = alucode inside {alu_pkg::alu_div, alu_pkg::alu_divu};

    // fixed-result cases, answered without iterating
    assign div_zero = (b == '0);
    assign overflow = signed_op & (a == {1'b1, {(xlen-1){1'b0}}}) & (b == '1);
    assign exc      = div_zero | overflow;

    assign busy = req & ~exc & (phase != alu_pkg::div_done);

    // trial subtract of the shifted divisor, wide enough to keep the sign
    assign diff  = {{xlen{1'b0}}, rem} - ({{xlen{1'b0}}, dvsr} << count);
    assign q_bit = ~diff[2*xlen-1];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase <= alu_pkg::div_idle;
            count <= '0;
        end else if (req) begin
            case (phase)
                alu_pkg::div_idle: begin
                    if (!exc) begin // exceptions never leave idle
                        phase <= alu_pkg::div_iterate;
                        count <= cnt_w'(xlen - 1);
                    end
                end
                alu_pkg::div_iterate: begin
                    if (count == '0)
                        phase <= alu_pkg::div_done;
                    else
                        count <= count - 1'b1;
                end
                default: phase <= alu_pkg::div_idle; // retire edge
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (req) begin
            case (phase)
                alu_pkg::div_idle: begin
                    rem   <= (signed_op & a[xlen-1]) ? -a : a;
                    dvsr  <= (signed_op & b[xlen-1]) ? -b : b;
                    neg_q <= signed_op & (a[xlen-1] ^ b[xlen-1]);
                    neg_r <= signed_op & a[xlen-1];
                    quo   <= '0;
                end
                alu_pkg::div_iterate: begin
                    if (q_bit)
                        rem <= diff[xlen-1:0];
                    quo[count] <= q_bit;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        if (div_zero)
            result = is_quot ? '1 : a; // riscv: all ones, rem keeps dividend
        else if (overflow)
            result = is_quot ? {1'b1, {(xlen-1){1'b0}}} : '0;
        else if (is_quot)
            result = neg_q ? -quo : quo;
        else
            result = neg_r ? -rem : rem;
    end

    // an exception request held in idle must not start the sequence
    a_exc_stays_idle: assert property (@(posedge clk) disable iff (!reset)
        (req && exc && phase == alu_pkg::div_idle) |=> (phase == alu_pkg::div_idle));

endmodule

// File: rtl/alu_top.sv
`timescale 1ns/1ps

module alu_top #(
    parameter int xlen = alu_pkg::xlen_default
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid,
    input  alu_pkg::alu_op_e  alucode,
    input  logic [xlen-1:0]   a,
    input  logic [xlen-1:0]   b,
    output logic [xlen-1:0]   result,
    output logic              busy
);

    logic [xlen-1:0] alu_result; // single-cycle path
    logic [xlen-1:0] mul_result;
    logic [xlen-1:0] div_result;
    logic            mul_busy;
    logic            div_busy;

    int_alu #(
        .xlen    (xlen)
    ) u_int_alu (
        .alucode (alucode),
        .a       (a),
        .b       (b),
        .result  (alu_result)
    );

    multiplier #(
        .xlen    (xlen)
    ) u_multiplier (
        .clk     (clk),
        .reset   (reset),
        .valid   (valid),
        .alucode (alucode),
        .a       (a),
        .b       (b),
        .result  (mul_result),
        .busy    (mul_busy)
    );

    divider #(
        .xlen    (xlen)
    ) u_divider (
        .clk     (clk),
        .reset   (reset),
        .valid   (valid),
        .alucode (alucode),
        .a       (a),
        .b       (b),
        .result  (div_result),
        .busy    (div_busy)
    );

    // each block already gates its own busy by opcode class
    assign busy = mul_busy | div_busy;

    // result mux by class
    assign result = alu_pkg::is_mul_op(alucode) ? mul_result
                  : alu_pkg::is_div_op(alucode) ? div_result
                  : alu_result;

endmodule

// File: tests/alu_checker.sv
`timescale 1ns/1ps

module alu_checker (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid,
    input  alu_pkg::alu_op_e alucode,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  logic [31:0]      result,
    input  logic             busy
);

    localparam int mul_cycles = 8;  // 1 load, 4 accumulate, 3 reduce
    localparam int div_cycles = 33; // 1 load, 32 quotient bits

    int error_count  = 0;
    int op_count     = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int test_ops     = 0;
    int test_errors  = 0;
    int busy_cycles  = 0; // busy-high cycles of the current request

    function automatic logic [31:0] expected_result(input alu_pkg::alu_op_e op,
                                                    input logic [31:0] x, input logic [31:0] y);
        logic [63:0] p;
        logic        ovf;
        ovf = (x == 32'h8000_0000) && (y == 32'hffff_ffff); // signed overflow pair
        case (op)
            alu_pkg::alu_add:  return x + y;
            alu_pkg::alu_sub:  return x - y;
            alu_pkg::alu_slt:  return {31'b0, $signed(x) < $signed(y)};
            alu_pkg::alu_sltu: return {31'b0, x < y};
            alu_pkg::alu_xor:  return x ^ y;
            alu_pkg::alu_or:   return x | y;
            alu_pkg::alu_and:  return x & y;
            alu_pkg::alu_sll:  return x << y[4:0];
            alu_pkg::alu_srl:  return x >> y[4:0];
            alu_pkg::alu_sra:  return $signed(x) >>> y[4:0];
            alu_pkg::alu_lui:  return y;
            alu_pkg::alu_mul: begin
                p = {32'b0, x} * {32'b0, y};
                return p[31:0];
            end
            alu_pkg::alu_mulh: begin
                p = {{32{x[31]}}, x} * {{32{y[31]}}, y}; // mod 2^64 is enough
                return p[63:32];
            end
            alu_pkg::alu_mulhsu: begin
                p = {{32{x[31]}}, x} * {32'b0, y};
                return p[63:32];
            end
            alu_pkg::alu_mulhu: begin
                p = {32'b0, x} * {32'b0, y};
                return p[63:32];
            end
            alu_pkg::alu_div: begin
                if (y == 0)
                    return '1;
                if (ovf)
                    return 32'h8000_0000;
                return $signed(x) / $signed(y); // truncates toward zero
            end
            alu_pkg::alu_divu: return (y == 0) ? '1 : x / y;
            alu_pkg::alu_rem: begin
                if (y == 0)
                    return x;
                if (ovf)
                    return '0;
                return $signed(x) % $signed(y); // sign of the dividend
            end
            alu_pkg::alu_remu: return (y == 0) ? x : x % y;
            default:           return '0;
        endcase
    endfunction

    function automatic int expected_busy_cycles(input alu_pkg::alu_op_e op,
                                                input logic [31:0] x, input logic [31:0] y);
        if (op inside {alu_pkg::alu_mul, alu_pkg::alu_mulh, alu_pkg::alu_mulhsu,
                       alu_pkg::alu_mulhu})
            return mul_cycles;
        if (!(op inside {alu_pkg::alu_div, alu_pkg::alu_divu, alu_pkg::alu_rem,
                         alu_pkg::alu_remu}))
            return 0;
        if (y == 0)
            return 0; // answered at once
        if ((op == alu_pkg::alu_div || op == alu_pkg::alu_rem)
            && x == 32'h8000_0000 && y == 32'hffff_ffff)
            return 0;
        return div_cycles;
    endfunction

    task automatic count_error();
        test_errors++;
        error_count++;
    endtask

    task automatic retire();
        logic [31:0] exp_result;
        int          exp_busy;
        exp_result = expected_result(alucode, a, b);
        exp_busy   = expected_busy_cycles(alucode, a, b);
        test_ops++;
        if (result !== exp_result) begin
            $display("FAIL result %s a=%h b=%h: got %h, expected %h",
                     alucode.name(), a, b, result, exp_result);
            count_error();
        end
        if (busy_cycles != exp_busy) begin
            $display("FAIL busy %s a=%h b=%h: high for %h cycles, expected %h",
                     alucode.name(), a, b, busy_cycles, exp_busy);
            count_error();
        end
        busy_cycles = 0;
    endtask

    // mid-cycle sampling, the retire edge follows
    always @(negedge clk) begin
        if (reset) begin
            if ($isunknown(busy)) begin
                $display("busy is unknown at %0t", $time);
                count_error();
            end else if (!valid) begin
                if (busy) begin
                    $display("busy is high while no request is valid at %0t", $time);
                    count_error();
                end
                busy_cycles = 0;
            end else if (busy) begin
                busy_cycles++;
            end else begin
                retire();
            end
        end
    end

    task automatic end_test(input string name, input int expected_ops);
        if (test_ops != expected_ops) begin
            $display("test %s retired %0d operations instead of %0d",
                     name, test_ops, expected_ops);
            count_error();
        end
        $display("test %-14s %s: %0d operations, %0d errors", name,
                 (test_errors == 0) ? "passed" : "failed", test_ops, test_errors);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        op_count    += test_ops;
        test_ops    = 0;
        test_errors = 0;
    endtask

    task automatic report_totals();
        $display("%0d tests, %0d failed, %0d operations, %0d errors",
                 tests_run, tests_failed, op_count, error_count);
    endtask

endmodule

// File: tests/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;

    localparam int timeout = 60; // cycles allowed per request

    logic             clk;
    logic             reset;
    logic             valid;
    alu_pkg::alu_op_e alucode;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      result;
    logic             busy;
    logic [31:0]      lfsr; // random state

    always #2 clk = ~clk; // 4 ns period

    alu_top #(
        .xlen    (32)
    ) UUT (
        .clk     (clk),
        .reset   (reset),
        .valid   (valid),
        .alucode (alucode),
        .a       (a),
        .b       (b),
        .result  (result),
        .busy    (busy)
    );

    alu_checker u_checker (
        .clk     (clk),
        .reset   (reset),
        .valid   (valid),
        .alucode (alucode),
        .a       (a),
        .b       (b),
        .result  (result),
        .busy    (busy)
    );

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]}; // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // mix of negative, small and plain values
    function automatic logic [31:0] biased_operand();
        logic [31:0] v;
        v = rand_bits(32);
        case (rand_bits(2))
            2'd0:    v[31] = 1'b1;
            2'd1:    v = {{16{v[15]}}, v[15:0]}; // small, either sign
            2'd2:    v = 32'h8000_0000 | (v >> 20); // near most negative
            default: ;
        endcase
        return v;
    endfunction

    // spread of magnitudes so quotients are not always 0 or 1
    function automatic logic [31:0] divisor_operand();
        logic [31:0] v;
        v = rand_bits(32) >> rand_bits(5);
        if (rand_bits(1))
            v = -v;
        if (v == '0)
            v = 32'd7;
        return v;
    endfunction

    // hold the request until busy is seen low, then step past the retire edge
    task automatic run_op(input alu_pkg::alu_op_e op, input logic [31:0] x,
                          input logic [31:0] y);
        int waited;
        valid   = 1'b1;
        alucode = op;
        a       = x;
        b       = y;
        waited  = 0;
        @(negedge clk); // mid cycle, inputs settled
        while (busy !== 1'b0 && waited < timeout) begin
            @(negedge clk);
            waited++;
        end
        if (busy !== 1'b0) begin
            $display("timeout: %s a=%h b=%h still busy after %0d cycles",
                     op.name(), x, y, timeout);
            $display("Simulation failed");
            $finish;
        end else begin
            @(posedge clk); // retire edge
            #1;
        end
    endtask

    task automatic idle_cycle();
        valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        int               idx;
        alu_pkg::alu_op_e op;
        logic [31:0]      x;
        logic [31:0]      y;
        clk     = 1'b0;
        reset   = 1'b0;
        valid   = 1'b0;
        alucode = alu_pkg::alu_add;
        a       = '0;
        b       = '0;
        lfsr    = 32'd5;
        repeat (3) @(posedge clk);
        #1 reset = 1'b1;

        repeat (4) @(posedge clk); // checker watches busy meanwhile
        #1;
        u_checker.end_test("reset_idle", 0);

        for (int i = 0; i < 200; i++) begin
            idx = rand_bits(4) % 11;
            op  = (idx == 10) ? alu_pkg::alu_lui : alu_pkg::alu_op_e'(idx); // add..sra, lui
            x   = rand_bits(32);
            y   = rand_bits(32);
            run_op(op, x, y);
            idle_cycle();
        end
        u_checker.end_test("single_cycle", 200);

        for (int i = 0; i < 100; i++) begin
            op = alu_pkg::alu_op_e'(alu_pkg::alu_mul + rand_bits(2)); // mul..mulhu
            x  = biased_operand();
            y  = biased_operand();
            run_op(op, x, y);
            idle_cycle();
        end
        u_checker.end_test("multiply", 100);

        for (int i = 0; i < 100; i++) begin
            op = alu_pkg::alu_op_e'(alu_pkg::alu_div + rand_bits(2)); // div..remu
            x  = biased_operand();
            y  = divisor_operand();
            if (x == 32'h8000_0000 && y == 32'hffff_ffff)
                y = 32'd3; // keep clear of signed overflow here
            run_op(op, x, y);
            idle_cycle();
        end
        u_checker.end_test("divide", 100);

        for (int k = 0; k < 4; k++) begin
            op = alu_pkg::alu_op_e'(alu_pkg::alu_div + k);
            run_op(op, rand_bits(32), 32'd0);
            idle_cycle();
            run_op(op, 32'h8000_0000, 32'hffff_ffff);
            idle_cycle();
        end
        u_checker.end_test("div_exceptions", 8);

        // no idle cycle between requests
        for (int i = 0; i < 150; i++) begin
            op = alu_pkg::alu_op_e'(rand_bits(5) % 19);
            x  = biased_operand();
            y  = biased_operand();
            if (rand_bits(3) == 0)
                y = '0; // occasional divide by zero
            run_op(op, x, y);
        end
        idle_cycle();
        u_checker.end_test("mixed", 150);

        u_checker.report_totals();
        if (u_checker.error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: list.f
rtl/alu_pkg.sv
rtl/int_alu.sv
rtl/multiplier.sv
rtl/divider.sv
rtl/alu_top.sv
tests/alu_checker.sv
tests/alu_tb.sv

// File: Bender.yml
package:
  name: alu

sources:
  - files:
      - rtl/alu_pkg.sv
      - rtl/int_alu.sv
      - rtl/multiplier.sv
      - rtl/divider.sv
      - rtl/alu_top.sv
  - target: test
    files:
      - tests/alu_checker.sv
      - tests/alu_tb.sv
